//--- Bender.yml
package:
  name: exec_core

sources:
  - hw/isaPkg.sv
  - hw/corePkg.sv
  - hw/decoder.sv
  - hw/alu.sv
  - hw/mulUnit.sv
  - hw/regFile.sv
  - hw/execCore.sv
  - target: test
    files:
      - test/execCore_sva.sv
      - test/tbExecCore.sv

//--- hw/alu.sv
`timescale 1ns/10ps

module alu
    import isaPkg::*;
    import corePkg::*;
(
    input  aluOpE aluOp,
    input  wordT  opA,
    input  wordT  opB,
    input  shamtT shamt,
    output wordT  result,
    output logic  writeCancel
);

    always_comb
    begin
        result      = '0;
        writeCancel = 1'b0;

        case (aluOp)
            aluAdd: result = opA + opB;
            aluSub: result = opA - opB;

            // Shifts act on the rt operand.
            aluSll: result = opB << shamt;
            aluSrl: result = opB >> shamt;
            aluSra: result = wordT'($signed(opB) >>> shamt);

            aluAnd: result = opA & opB;
            aluOr:  result = opA | opB;
            aluXor: result = opA ^ opB;
            aluNor: result = ~(opA | opB);

            aluSlt:  result = wordT'($signed(opA) < $signed(opB));
            aluSltu: result = wordT'(opA < opB);

            aluMovn:
            begin
                result      = opA;
                writeCancel = (opB == '0);  // Move only if rt is non-zero.
            end

            aluMovz:
            begin
                result      = opA;
                writeCancel = (opB != '0);
            end

            aluLui: result = opB << 16;

            default:
            begin
                result      = '0;
                writeCancel = 1'b0;
            end
        endcase
    end

endmodule

//--- hw/corePkg.sv
package corePkg;

    typedef logic [31:0] wordT;
    typedef logic [63:0] dwordT;

    typedef enum logic [4:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSrl,
        aluSra,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluMovn,
        aluMovz,
        aluLui
    } aluOpE;

    typedef enum logic [3:0] {
        hlNone,
        hlMult,
        hlMultu,
        hlMadd,
        hlMaddu,
        hlMsub,
        hlMsubu,
        hlMul,
        hlMthi,
        hlMtlo,
        hlMfhi,
        hlMflo
    } hiLoOpE;

    typedef struct packed {
        logic   regDst;   // rd when set, rt otherwise.
        logic   aluSrc;
        logic   zeroExt;
        logic   varShift;
        logic   regWrite;
        logic   useHiLo;
        aluOpE  aluOp;
        hiLoOpE hiLoOp;
    } ctrlT;

endpackage

//--- hw/decoder.sv
`timescale 1ns/10ps

module decoder
    import isaPkg::*;
    import corePkg::*;
(
    input  instrT instr,
    output ctrlT  ctrl
);

    rFieldsT fields;

    assign fields = instr;

    always_comb
    begin
        ctrl        = '0;
        ctrl.aluOp  = aluAdd;
        ctrl.hiLoOp = hlNone;

        case (fields.opcode)
            opSpecial:
            begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (fields.funct)
                    fnAdd, fnAddu: ctrl.aluOp = aluAdd;  // No overflow trap.
                    fnSub, fnSubu: ctrl.aluOp = aluSub;
                    fnSll:         ctrl.aluOp = aluSll;
                    fnSrl:         ctrl.aluOp = aluSrl;
                    fnSra:         ctrl.aluOp = aluSra;
                    fnSllv:
                    begin
                        ctrl.aluOp    = aluSll;
                        ctrl.varShift = 1'b1;
                    end
                    fnSrlv:
                    begin
                        ctrl.aluOp    = aluSrl;
                        ctrl.varShift = 1'b1;
                    end
                    fnSrav:
                    begin
                        ctrl.aluOp    = aluSra;
                        ctrl.varShift = 1'b1;
                    end
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnXor:  ctrl.aluOp = aluXor;
                    fnNor:  ctrl.aluOp = aluNor;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSltu: ctrl.aluOp = aluSltu;
                    fnMovn: ctrl.aluOp = aluMovn;
                    fnMovz: ctrl.aluOp = aluMovz;
                    fnMfhi:
                    begin
                        ctrl.useHiLo = 1'b1;
                        ctrl.hiLoOp  = hlMfhi;
                    end
                    fnMflo:
                    begin
                        ctrl.useHiLo = 1'b1;
                        ctrl.hiLoOp  = hlMflo;
                    end
                    // These only touch HI/LO.
                    fnMult:
                    begin
                        ctrl.regWrite = 1'b0;
                        ctrl.hiLoOp   = hlMult;
                    end
                    fnMultu:
                    begin
                        ctrl.regWrite = 1'b0;
                        ctrl.hiLoOp   = hlMultu;
                    end
                    fnMthi:
                    begin
                        ctrl.regWrite = 1'b0;
                        ctrl.hiLoOp   = hlMthi;
                    end
                    fnMtlo:
                    begin
                        ctrl.regWrite = 1'b0;
                        ctrl.hiLoOp   = hlMtlo;
                    end
                    default: ctrl.regWrite = 1'b0;
                endcase
            end

            opSpecial2:
            begin
                case (fields.funct)
                    fn2Madd:  ctrl.hiLoOp = hlMadd;
                    fn2Maddu: ctrl.hiLoOp = hlMaddu;
                    fn2Msub:  ctrl.hiLoOp = hlMsub;
                    fn2Msubu: ctrl.hiLoOp = hlMsubu;
                    fn2Mul:
                    begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.useHiLo  = 1'b1;
                        ctrl.hiLoOp   = hlMul;
                    end
                    default: ctrl.hiLoOp = hlNone;
                endcase
            end

            opAddi, opAddiu:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            opSlti, opSltiu:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = (fields.opcode == opSlti) ? aluSlt : aluSltu;
            end

            opAndi, opOri, opXori, opLui:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.zeroExt  = 1'b1;
                ctrl.regWrite = 1'b1;
                case (fields.opcode)
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    default: ctrl.aluOp = aluLui;
                endcase
            end

            default: ctrl.regWrite = 1'b0;  // Unsupported, no effect.
        endcase
    end

endmodule

//--- hw/execCore.sv
`timescale 1ns/10ps

module execCore
    import isaPkg::*;
    import corePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    instrValid,
    input  instrT   instr,
    output logic    wbValid,
    output regAddrT wbReg,
    output wordT    wbData
);

    rFieldsT rFields;
    iFieldsT iFields;
    ctrlT    ctrl;
    wordT    rsData;
    wordT    rtData;
    wordT    immExt;
    wordT    opB;
    shamtT   shamt;
    wordT    aluResult;
    logic    writeCancel;
    wordT    hiLoResult;
    wordT    result;
    regAddrT dest;
    logic    we;

    assign rFields = instr;
    assign iFields = instr;

    decoder decoder_i (.instr(instr), .ctrl(ctrl));

    regFile regFile_i (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rFields.rs),
        .rdAddrB (rFields.rt),
        .rdDataA (rsData),
        .rdDataB (rtData),
        .we      (we),
        .wrAddr  (dest),
        .wrData  (result)
    );

    assign immExt = ctrl.zeroExt ? {16'h0000, iFields.imm}
                                 : {{16{iFields.imm[15]}}, iFields.imm};
    assign opB    = ctrl.aluSrc ? immExt : rtData;
    assign shamt  = ctrl.varShift ? rsData[4:0] : rFields.shamt;

    alu alu_i (
        .aluOp       (ctrl.aluOp),
        .opA         (rsData),
        .opB         (opB),
        .shamt       (shamt),
        .result      (aluResult),
        .writeCancel (writeCancel)
    );

    mulUnit mulUnit_i (
        .clk    (clk),
        .rst    (rst),
        .en     (instrValid),
        .hiLoOp (ctrl.hiLoOp),
        .opA    (rsData),
        .opB    (rtData),
        .result (hiLoResult)
    );

    assign result = ctrl.useHiLo ? hiLoResult : aluResult;
    assign dest   = ctrl.regDst ? rFields.rd : rFields.rt;

    // Writes to r0 are dropped, so they never show on the write-back port.
    assign we = instrValid && ctrl.regWrite && !writeCancel && (dest != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
            wbValid <= 1'b0;
        else
            wbValid <= we;
    end

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            wbReg  <= dest;
            wbData <= result;
        end
    end

endmodule

//--- hw/isaPkg.sv
package isaPkg;

    localparam int unsigned numRegs = 32;

    typedef logic [31:0] instrT;
    typedef logic [4:0]  regAddrT;
    typedef logic [4:0]  shamtT;
    typedef logic [15:0] imm16T;

    // Field layout of an R-type word.
    typedef struct packed {
        logic [5:0] opcode;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    rd;
        shamtT      shamt;
        logic [5:0] funct;
    } rFieldsT;

    // I-type overlays rd, shamt and funct with the immediate.
    typedef struct packed {
        logic [5:0] opcode;
        regAddrT    rs;
        regAddrT    rt;
        imm16T      imm;
    } iFieldsT;

    typedef enum logic [5:0] {
        opSpecial  = 6'h00,
        opAddi     = 6'h08,
        opAddiu    = 6'h09,
        opSlti     = 6'h0A,
        opSltiu    = 6'h0B,
        opAndi     = 6'h0C,
        opOri      = 6'h0D,
        opXori     = 6'h0E,
        opLui      = 6'h0F,
        opSpecial2 = 6'h1C
    } opcodeE;

    typedef enum logic [5:0] {
        fnSll = 6'h00, fnSrl = 6'h02, fnSra = 6'h03, fnSllv = 6'h04,
        fnSrlv = 6'h06, fnSrav = 6'h07, fnMovz = 6'h0A, fnMovn = 6'h0B,
        fnMfhi = 6'h10, fnMthi = 6'h11, fnMflo = 6'h12, fnMtlo = 6'h13,
        fnMult = 6'h18, fnMultu = 6'h19, fnAdd = 6'h20, fnAddu = 6'h21,
        fnSub = 6'h22, fnSubu = 6'h23, fnAnd = 6'h24, fnOr = 6'h25,
        fnXor = 6'h26, fnNor = 6'h27, fnSlt = 6'h2A, fnSltu = 6'h2B
    } functE;

    typedef enum logic [5:0] {
        fn2Madd  = 6'h00,
        fn2Maddu = 6'h01,
        fn2Mul   = 6'h02,
        fn2Msub  = 6'h04,
        fn2Msubu = 6'h05
    } funct2E;

endpackage

//--- hw/mulUnit.sv
`timescale 1ns/10ps

module mulUnit
    import corePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   en,
    input  hiLoOpE hiLoOp,
    input  wordT   opA,
    input  wordT   opB,
    output wordT   result
);

    wordT               hi;
    wordT               lo;
    logic signed [63:0] prodS;
    dwordT              prodU;
    dwordT              prod;
    logic               signedOp;

    // Operands widen to 64 bits before the multiply.
    assign prodS    = $signed(opA) * $signed(opB);
    assign prodU    = opA * opB;
    assign signedOp = hiLoOp inside {hlMult, hlMadd, hlMsub, hlMul};
    assign prod     = signedOp ? dwordT'(prodS) : prodU;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hi <= '0;
            lo <= '0;
        end
        else if (en)
        begin
            case (hiLoOp)
                hlMult, hlMultu: {hi, lo} <= prod;
                hlMadd, hlMaddu: {hi, lo} <= {hi, lo} + prod;
                hlMsub, hlMsubu: {hi, lo} <= {hi, lo} - prod;
                hlMthi:          hi <= opA;
                hlMtlo:          lo <= opA;
                default:         ;  // MUL and moves out leave HI/LO alone.
            endcase
        end
    end

    always_comb
    begin
        case (hiLoOp)
            hlMfhi:  result = hi;
            hlMflo:  result = lo;
            hlMul:   result = prod[31:0];
            default: result = '0;
        endcase
    end

endmodule

//--- hw/regFile.sv
`timescale 1ns/10ps

module regFile
    import isaPkg::*;
    import corePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  regAddrT rdAddrA,
    input  regAddrT rdAddrB,
    output wordT    rdDataA,
    output wordT    rdDataB,
    input  logic    we,
    input  regAddrT wrAddr,
    input  wordT    wrData
);

    wordT regs [numRegs];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < numRegs; i++)
                regs[i] <= '0;
        end
        else if (we && wrAddr != '0)
            regs[wrAddr] <= wrData;
    end

    // Register 0 is hardwired.
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- tb.f
hw/isaPkg.sv
hw/corePkg.sv
hw/decoder.sv
hw/alu.sv
hw/mulUnit.sv
hw/regFile.sv
hw/execCore.sv
test/execCore_sva.sv
test/tbExecCore.sv

//--- test/execCore_sva.sv
`timescale 1ns/10ps

module execCoreSva
    import isaPkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    instrValid,
    input logic    wbValid,
    input regAddrT wbReg
);

    int failures = 0;

    assert property (@(posedge clk) rst |=> !wbValid)
    else
    begin
        failures++;
        $error("wbValid is high in the cycle after reset");
    end

    // Fixed one-cycle latency.
    assert property (@(posedge clk) disable iff (rst) wbValid |-> $past(instrValid))
    else
    begin
        failures++;
        $error("wbValid without an accepted instruction one cycle earlier");
    end

    assert property (@(posedge clk) disable iff (rst) wbValid |-> wbReg != '0)
    else
    begin
        failures++;
        $error("Write-back reported for register 0");
    end

endmodule

bind execCore execCoreSva execCoreSva_i (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .wbValid    (wbValid),
    .wbReg      (wbReg)
);

//--- test/tbExecCore.sv
`timescale 1ns/10ps

module tbExecCore
    import isaPkg::*;
    import corePkg::*;
;

    localparam int numRandom   = 2000;
    localparam int numDirected = 64;   // Upper bound on the directed steps.
    localparam int numInstr    = numRandom + numDirected;

    logic    clk = 1'b0;
    logic    rst;
    logic    instrValid;
    instrT   instr;
    logic    wbValid;
    regAddrT wbReg;
    wordT    wbData;

    integer  seed = 70;
    int      valueErrors = 0;
    int      protocolErrors = 0;
    int      checks = 0;

    // Reference state.
    wordT    model [32];
    wordT    hiModel;
    wordT    loModel;

    // Write-back predicted for the instruction issued last cycle.
    logic    expValid;
    regAddrT expReg;
    wordT    expData;
    string   expName;

    functE specialFns [24] = '{fnAdd, fnAddu, fnSub, fnSubu, fnSll, fnSllv, fnSra, fnSrav,
                               fnSrl, fnSrlv, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu,
                               fnMovn, fnMovz, fnMult, fnMultu, fnMfhi, fnMflo, fnMthi,
                               fnMtlo};
    funct2E special2Fns [5] = '{fn2Madd, fn2Maddu, fn2Msub, fn2Msubu, fn2Mul};
    opcodeE immOps [8] = '{opAddi, opAddiu, opAndi, opOri, opXori, opSlti, opSltiu, opLui};

    always #20 clk = ~clk;

    execCore execCore_i (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    function automatic instrT encodeR(input logic [5:0] op, input logic [5:0] fn,
                                      input regAddrT rs, input regAddrT rt,
                                      input regAddrT rd, input shamtT sa);
        return {op, rs, rt, rd, sa, fn};
    endfunction

    function automatic instrT encodeI(input logic [5:0] op, input regAddrT rs,
                                      input regAddrT rt, input imm16T imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic regAddrT randReg();
        logic [31:0] r;
        r = $random(seed);
        // Mostly low registers so that results feed later instructions.
        return r[31] ? regAddrT'(r[4:0]) : regAddrT'(r[2:0]);
    endfunction

    task automatic checkReg(input string testName, input regAddrT expected,
                            input regAddrT actual);
        checks++;
        if (expected !== actual)
        begin
            valueErrors++;
            $display("FAILED %s: wbReg expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    task automatic checkWord(input string testName, input wordT expected, input wordT actual);
        checks++;
        if (expected !== actual)
        begin
            valueErrors++;
            $display("FAILED %s: wbData expected 0x%08h, actual 0x%08h",
                     testName, expected, actual);
        end
    endtask

    task automatic compareWriteBack();
        if (expValid && wbValid !== 1'b1)
        begin
            protocolErrors++;
            $display("Write-back missing for %s at %0t", expName, $time);
        end
        else if (!expValid && wbValid !== 1'b0)
        begin
            protocolErrors++;
            $display("Unexpected write-back after %s at %0t", expName, $time);
        end
        else if (expValid)
        begin
            checkReg(expName, expReg, wbReg);
            checkWord(expName, expData, wbData);
        end
    endtask

    // Applies one instruction to the model and predicts its write-back.
    task automatic predict(input instrT ins, input string name);
        rFieldsT f;
        iFieldsT fi;
        wordT    a;
        wordT    b;
        wordT    sImm;
        wordT    zImm;
        wordT    res;
        dwordT   sProd;
        dwordT   uProd;
        regAddrT dst;
        logic    wr;

        f     = ins;
        fi    = ins;
        a     = model[f.rs];
        b     = model[f.rt];
        sImm  = {{16{fi.imm[15]}}, fi.imm};
        zImm  = {16'h0000, fi.imm};
        sProd = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        uProd = {32'h0, a} * {32'h0, b};
        res   = '0;
        wr    = 1'b0;
        dst   = f.rd;

        case (f.opcode)
            opSpecial:
            begin
                wr = 1'b1;
                case (f.funct)
                    fnAdd, fnAddu: res = a + b;
                    fnSub, fnSubu: res = a - b;
                    fnSll:  res = b << f.shamt;
                    fnSllv: res = b << a[4:0];
                    fnSrl:  res = b >> f.shamt;
                    fnSrlv: res = b >> a[4:0];
                    fnSra:  res = $signed(b) >>> f.shamt;
                    fnSrav: res = $signed(b) >>> a[4:0];
                    fnAnd:  res = a & b;
                    fnOr:   res = a | b;
                    fnXor:  res = a ^ b;
                    fnNor:  res = ~(a | b);
                    fnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fnSltu: res = (a < b) ? 32'd1 : 32'd0;
                    fnMovn:
                    begin
                        res = a;
                        wr  = (b != '0);
                    end
                    fnMovz:
                    begin
                        res = a;
                        wr  = (b == '0);
                    end
                    fnMfhi: res = hiModel;
                    fnMflo: res = loModel;
                    fnMult:
                    begin
                        {hiModel, loModel} = sProd;
                        wr = 1'b0;
                    end
                    fnMultu:
                    begin
                        {hiModel, loModel} = uProd;
                        wr = 1'b0;
                    end
                    fnMthi:
                    begin
                        hiModel = a;
                        wr      = 1'b0;
                    end
                    fnMtlo:
                    begin
                        loModel = a;
                        wr      = 1'b0;
                    end
                    default: wr = 1'b0;
                endcase
            end
            opSpecial2:
            begin
                case (f.funct)
                    fn2Madd:  {hiModel, loModel} = {hiModel, loModel} + sProd;
                    fn2Maddu: {hiModel, loModel} = {hiModel, loModel} + uProd;
                    fn2Msub:  {hiModel, loModel} = {hiModel, loModel} - sProd;
                    fn2Msubu: {hiModel, loModel} = {hiModel, loModel} - uProd;
                    fn2Mul:
                    begin
                        res = sProd[31:0];
                        wr  = 1'b1;
                    end
                    default: wr = 1'b0;
                endcase
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui:
            begin
                dst = fi.rt;
                wr  = 1'b1;
                case (f.opcode)
                    opAddi, opAddiu: res = a + sImm;   // No overflow trap.
                    opSlti:  res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
                    opSltiu: res = (a < sImm) ? 32'd1 : 32'd0;
                    opAndi:  res = a & zImm;
                    opOri:   res = a | zImm;
                    opXori:  res = a ^ zImm;
                    default: res = {fi.imm, 16'h0000};
                endcase
            end
            default: wr = 1'b0;
        endcase

        expName  = name;
        expValid = wr && (dst != '0);
        expReg   = dst;
        expData  = res;
        if (expValid)
            model[dst] = res;
    endtask

    task automatic drawInstr(output instrT ins, output string name);
        logic [31:0] r;
        int unsigned kind;
        regAddrT     rs;
        regAddrT     rt;
        regAddrT     rd;
        functE       fn;
        funct2E      fn2;
        opcodeE      op;

        r    = $random(seed);
        kind = r % 38;
        rs   = randReg();
        rt   = randReg();
        rd   = randReg();
        r    = $random(seed);
        if (kind < 24)
        begin
            fn   = specialFns[kind];
            ins  = encodeR(opSpecial, fn, rs, rt, rd, r[20:16]);
            name = fn.name();
        end
        else if (kind < 29)
        begin
            fn2  = special2Fns[kind - 24];
            ins  = encodeR(opSpecial2, fn2, rs, rt, rd, 5'd0);
            name = fn2.name();
        end
        else if (kind < 37)
        begin
            op   = immOps[kind - 29];
            ins  = encodeI(op, rs, rt, r[15:0]);
            name = op.name();
        end
        else
        begin
            ins  = encodeI(6'h23, rs, rt, r[15:0]);   // Load word is not supported.
            name = "unsupported";
        end
    endtask

    // Checks last cycle's write-back, then drives the next input.
    task automatic step(input logic valid, input instrT ins, input string name);
        compareWriteBack();
        instrValid = valid;
        instr      = ins;
        if (valid)
            predict(ins, name);
        else
        begin
            expValid = 1'b0;
            expName  = name;
        end
        @(negedge clk);
    endtask

    initial
    begin
        #((numInstr + 20) * 40 * 2);
        $display("Timeout after %0t, the run did not complete", $time);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        instrT       ins;
        string       name;
        logic [31:0] r;
        int          issued;

        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        expValid   = 1'b0;
        expName    = "reset";
        hiModel    = '0;
        loModel    = '0;
        for (int i = 0; i < 32; i++)
            model[i] = '0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Every register, HI and LO start at zero.
        for (int i = 1; i < 32; i++)
            step(1'b1, encodeR(opSpecial, fnAddu, regAddrT'(i), 5'd0, regAddrT'(i), 5'd0),
                 $sformatf("reset read r%0d", i));
        step(1'b1, encodeR(opSpecial, fnMfhi, 5'd0, 5'd0, 5'd1, 5'd0), "reset MFHI");
        step(1'b1, encodeR(opSpecial, fnMflo, 5'd0, 5'd0, 5'd2, 5'd0), "reset MFLO");

        // Register 0 ignores writes.
        step(1'b1, encodeI(opAddiu, 5'd0, 5'd0, 16'h1234), "write r0");
        step(1'b1, encodeR(opSpecial, fnAddu, 5'd0, 5'd0, 5'd5, 5'd0), "read r0");

        // Dependent chain with no gaps.
        step(1'b1, encodeI(opLui, 5'd0, 5'd3, 16'h8000), "chain LUI");
        step(1'b1, encodeI(opOri, 5'd3, 5'd3, 16'h0001), "chain ORI");
        step(1'b1, encodeR(opSpecial, fnAddu, 5'd3, 5'd3, 5'd4, 5'd0), "chain ADDU");
        step(1'b1, encodeR(opSpecial, fnMult, 5'd3, 5'd4, 5'd0, 5'd0), "chain MULT");
        step(1'b1, encodeR(opSpecial, fnMfhi, 5'd0, 5'd0, 5'd6, 5'd0), "chain MFHI");
        step(1'b1, encodeR(opSpecial, fnMflo, 5'd0, 5'd0, 5'd7, 5'd0), "chain MFLO");
        step(1'b1, encodeR(opSpecial, fnMthi, 5'd4, 5'd0, 5'd0, 5'd0), "chain MTHI");
        step(1'b1, encodeR(opSpecial, fnMfhi, 5'd0, 5'd0, 5'd8, 5'd0), "chain MFHI after MTHI");
        step(1'b1, encodeR(opSpecial2, fn2Mul, 5'd3, 5'd8, 5'd9, 5'd0), "chain MUL");

        issued = 0;
        while (issued < numRandom)
        begin
            r = $random(seed);
            drawInstr(ins, name);
            if (r[1:0] == 2'b00)
                step(1'b0, ins, "idle");   // Garbage on the bus without a strobe.
            else
            begin
                issued++;
                step(1'b1, ins, $sformatf("random %s #%0d", name, issued));
            end
        end
        compareWriteBack();
        instrValid = 1'b0;

        $display("Checks: %0d, value errors: %0d, protocol errors: %0d, assertion failures: %0d",
                 checks, valueErrors, protocolErrors, execCore_i.execCoreSva_i.failures);
        if (valueErrors == 0 && protocolErrors == 0 && execCore_i.execCoreSva_i.failures == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule
